// File: dv/fetch_tests.txt
# M addr byte : preload one memory byte, hex.
# T pc x y opcode ea operand next_pc illegal : command and expected result, hex.
M 0200 a5
M 0201 10
M 0202 b5
M 0203 f0
M 0204 a9
M 0205 7e
M 0206 ad
M 0207 00
M 0208 02
M 0209 bd
M 020a f0
M 020b 01
M 020c b9
M 020d f0
M 020e ff
M 020f a1
M 0210 fe
M 0211 b1
M 0212 80
M 0213 ea
M 0214 b1
M 0215 ff
M 0216 4c
M 0010 33
M 00ff 06
M 0000 02
M 0080 f4
M 0081 01
T 0200 55 66 a5 0010 33 0202 0   # zpg
T 0202 20 00 b5 0010 33 0204 0   # zpg,x wraps at 8 bits
T 0204 00 00 a9 0205 7e 0206 0   # immediate
T 0206 00 00 ad 0200 a5 0209 0   # abs
T 0209 13 00 bd 0203 f0 020c 0   # abs,x
T 020c 00 20 b9 0010 33 020f 0   # abs,y wraps at 16 bits
T 020f 01 00 a1 0206 ad 0211 0   # (zp,x) pointer wraps
T 0211 00 10 b1 0204 a9 0213 0   # (zp),y
T 0213 77 88 ea 0000 00 0214 1   # group two, illegal
T 0214 00 03 b1 0209 bd 0216 0   # (zp),y pointer wraps
T 0216 00 00 4c 0000 00 0217 1   # group zero, illegal
T 0202 0f 00 b5 00ff 06 0204 0   # zpg,x without wrap

// File: fetch_unit_top.f
hw/fetch_pkg.sv
hw/program_memory.sv
hw/mem_arbiter.sv
hw/fetcher.sv
hw/operand_loader.sv
hw/fetch_unit_top.sv
dv/fetch_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it, look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fetch_unit_tb \
        -f fetch_unit_top.f -o fetch_sim &&
out=$(./obj_dir/fetch_sim 2>&1 || true) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: dv/fetch_unit_tb.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// fetch unit testbench: preloads program memory, sends commands and
// checks every result in command order under random response delays.
// ~~~~~~~~~~~~~~~~~~~~
module fetch_unit_tb
        import fetch_pkg::*;
();

        logic                  instruction_done;
        logic                  reset_n;
        logic                  cmd_req;
        fetch_cmd_t            cmd;
        logic                  cmd_ack;
        logic                  rsp_req;
        fetch_result_t         rsp;
        logic                  rsp_ack;
        logic                  load_en;
        logic [ADDR_WIDTH-1:0] load_addr;
        logic [DATA_WIDTH-1:0] load_data;

        fetch_cmd_t            cmds[$];
        fetch_result_t         expected[$];
        logic [ADDR_WIDTH-1:0] preload_addr[$];
        logic [DATA_WIDTH-1:0] preload_data[$];
        logic [31:0]           rng = 32'hb343_e585;
        int                    n_acked;
        int                    n_checked;
        int                    limit;

        fetch_unit_top i_fetch_unit_top (
                .instruction_done (instruction_done),
                .reset_n          (reset_n),
                .cmd_req          (cmd_req),
                .cmd              (cmd),
                .cmd_ack          (cmd_ack),
                .rsp_req          (rsp_req),
                .rsp              (rsp),
                .rsp_ack          (rsp_ack),
                .load_en          (load_en),
                .load_addr        (load_addr),
                .load_data        (load_data)
        );

        initial begin
                instruction_done = 1'b0;
                forever #4 instruction_done = ~instruction_done;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] s);
                logic [31:0] v;
                v = s ^ (s << 13);
                v = v ^ (v >> 17);
                v = v ^ (v << 5);
                return v;
        endfunction

        task automatic fail_run(input string what);
                $display("%s", what);
                $display("FAIL: see errors above");
                $fatal(1, "simulation stopped");
        endtask

        task automatic next_cycle();
                @(posedge instruction_done);
                #1;   // inputs move just after the edge.
        endtask

        task automatic random_wait();
                rng = xorshift32(rng);
                repeat (rng % 6) next_cycle();
        endtask

        task automatic check_field(input string name, input int idx,
                                   input logic [15:0] got, input logic [15:0] want);
                assert (got === want) else
                        fail_run($sformatf("** Error at time %0t: result %0d %s is %h, expected %h",
                                           $time, idx, name, got, want));
        endtask

        task automatic check_idle_outputs();
                assert (!cmd_ack && !rsp_req) else
                        fail_run("cmd_ack or rsp_req went high before any command was sent");
        endtask

        task automatic read_tests();
                int                    fd;
                int                    n;
                string                 line;
                logic [ADDR_WIDTH-1:0] a, pc, ea, npc;
                logic [DATA_WIDTH-1:0] d, x, y, op, opnd;
                logic                  il;
                fd = $fopen("dv/fetch_tests.txt", "r");
                if (fd == 0) fail_run("cannot open the test file dv/fetch_tests.txt");
                while (!$feof(fd)) begin
                        line = "";
                        void'($fgets(line, fd));
                        if (line.len() > 0 && line.getc(0) == "M") begin
                                n = $sscanf(line, "M %h %h", a, d);
                                if (n != 2) fail_run({"bad preload line: ", line});
                                preload_addr.push_back(a);
                                preload_data.push_back(d);
                        end else if (line.len() > 0 && line.getc(0) == "T") begin
                                n = $sscanf(line, "T %h %h %h %h %h %h %h %h",
                                            pc, x, y, op, ea, opnd, npc, il);
                                if (n != 8) fail_run({"bad test line: ", line});
                                cmds.push_back(fetch_cmd_t'{pc: pc, x: x, y: y});
                                expected.push_back(fetch_result_t'{opcode: op, ea: ea,
                                        operand: opnd, next_pc: npc, illegal: il});
                        end
                end
                $fclose(fd);
                if (cmds.size() == 0) fail_run("the test file holds no test lines");
        endtask

        task automatic preload_memory();
                foreach (preload_addr[i]) begin
                        load_en   = 1'b1;
                        load_addr = preload_addr[i];
                        load_data = preload_data[i];
                        next_cycle();
                        check_idle_outputs();
                end
                load_en = 1'b0;
                next_cycle();
                check_idle_outputs();
        endtask

        task automatic send_commands();
                foreach (cmds[i]) begin
                        random_wait();
                        cmd     = cmds[i];
                        cmd_req = 1'b1;
                        next_cycle();
                        while (!cmd_ack) next_cycle();
                        n_acked++;
                        cmd_req = 1'b0;
                        while (cmd_ack) next_cycle();
                end
        endtask

        task automatic collect_results();
                fetch_result_t want;
                for (int i = 0; i < expected.size(); i++) begin
                        while (!rsp_req) next_cycle();
                        want = expected[i];
                        assert (n_acked > i) else
                                fail_run("a result came back before its command was accepted");
                        check_field("opcode", i, {8'h00, rsp.opcode}, {8'h00, want.opcode});
                        check_field("ea", i, rsp.ea, want.ea);
                        check_field("operand", i, {8'h00, rsp.operand}, {8'h00, want.operand});
                        check_field("next_pc", i, rsp.next_pc, want.next_pc);
                        check_field("illegal", i, {15'd0, rsp.illegal}, {15'd0, want.illegal});
                        n_checked++;
                        random_wait();   // back-pressure on the loader.
                        rsp_ack = 1'b1;
                        next_cycle();
                        while (rsp_req) next_cycle();
                        rsp_ack = 1'b0;
                end
        endtask

        initial begin
                reset_n   = 1'b0;
                cmd_req   = 1'b0;
                cmd       = '0;
                rsp_ack   = 1'b0;
                load_en   = 1'b0;
                load_addr = '0;
                load_data = '0;
                n_acked   = 0;
                n_checked = 0;
                read_tests();
                limit = 200 * (cmds.size() + preload_addr.size());
                fork
                        begin
                                repeat (limit) @(posedge instruction_done);
                                fail_run($sformatf("timeout: only %0d of %0d results after %0d cycles",
                                                   n_checked, cmds.size(), limit));
                        end
                        begin
                                repeat (8) next_cycle();
                                reset_n = 1'b1;
                                preload_memory();
                                fork
                                        send_commands();
                                        collect_results();
                                join
                                $display("PASS: all tests");
                                $finish;
                        end
                join_any
        end

endmodule

// File: hw/fetch_unit_top.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// fetch unit top: fetcher and loader sharing program memory.
// ~~~~~~~~~~~~~~~~~~~~
module fetch_unit_top import fetch_pkg::*; (
        input  logic                  instruction_done,
        input  logic                  reset_n,
        input  logic                  cmd_req,
        input  fetch_cmd_t            cmd,
        output logic                  cmd_ack,
        output logic                  rsp_req,
        output fetch_result_t         rsp,
        input  logic                  rsp_ack,
        input  logic                  load_en,
        input  logic [ADDR_WIDTH-1:0] load_addr,
        input  logic [DATA_WIDTH-1:0] load_data
);

        mem_req_t              fetch_mreq;
        mem_rsp_t              fetch_mrsp;
        mem_req_t              load_mreq;
        mem_rsp_t              load_mrsp;
        logic                  item_req;
        logic                  item_ack;
        fetch_item_t           item;
        logic [ADDR_WIDTH-1:0] rd_addr;
        logic [DATA_WIDTH-1:0] rd_data;

        fetcher i_fetcher (
                .instruction_done (instruction_done),
                .reset_n          (reset_n),
                .cmd_req          (cmd_req),
                .cmd              (cmd),
                .cmd_ack          (cmd_ack),
                .mreq             (fetch_mreq),
                .mrsp             (fetch_mrsp),
                .item_req         (item_req),
                .item             (item),
                .item_ack         (item_ack)
        );

        operand_loader i_operand_loader (
                .instruction_done (instruction_done),
                .reset_n          (reset_n),
                .item_req         (item_req),
                .item             (item),
                .item_ack         (item_ack),
                .mreq             (load_mreq),
                .mrsp             (load_mrsp),
                .rsp_req          (rsp_req),
                .rsp              (rsp),
                .rsp_ack          (rsp_ack)
        );

        mem_arbiter i_mem_arbiter (
                .instruction_done (instruction_done),
                .reset_n          (reset_n),
                .fetch_mreq       (fetch_mreq),
                .fetch_mrsp       (fetch_mrsp),
                .load_mreq        (load_mreq),
                .load_mrsp        (load_mrsp),
                .rd_addr          (rd_addr),
                .rd_data          (rd_data)
        );

        program_memory i_program_memory (
                .instruction_done (instruction_done),
                .reset_n          (reset_n),
                .rd_addr          (rd_addr),
                .rd_data          (rd_data),
                .load_en          (load_en),
                .load_addr        (load_addr),
                .load_data        (load_data)
        );

endmodule

// File: hw/operand_loader.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// operand loader: reads the byte at ea when needed, returns result.
// ~~~~~~~~~~~~~~~~~~~~
module operand_loader import fetch_pkg::*; (
        input  logic          instruction_done,
        input  logic          reset_n,
        input  logic          item_req,
        input  fetch_item_t   item,
        output logic          item_ack,
        output mem_req_t      mreq,
        input  mem_rsp_t      mrsp,
        output logic          rsp_req,
        output fetch_result_t rsp,
        input  logic          rsp_ack
);

        typedef enum logic [1:0] {L_IDLE, L_MEM, L_RSP} lstate_t;

        lstate_t state;

        always_ff @(posedge instruction_done) begin
                if (!reset_n) begin
                        state    <= L_IDLE;
                        item_ack <= 1'b0;
                        mreq.req <= 1'b0;
                        rsp_req  <= 1'b0;
                end else begin
                        if (item_ack && !item_req) begin
                                item_ack <= 1'b0;
                        end
                        case (state)
                                L_IDLE: begin
                                        if (item_req && !item_ack && !mrsp.ack) begin
                                                item_ack    <= 1'b1;
                                                rsp.opcode  <= item.opcode;
                                                rsp.ea      <= item.ea;
                                                rsp.operand <= item.operand;
                                                rsp.next_pc <= item.next_pc;
                                                rsp.illegal <= item.illegal;
                                                mreq.req    <= item.needs_load;
                                                mreq.addr   <= item.ea;
                                                state       <= item.needs_load ? L_MEM : L_RSP;
                                        end
                                end
                                L_MEM: begin
                                        if (mrsp.ack) begin
                                                rsp.operand <= mrsp.data;
                                                mreq.req    <= 1'b0;
                                                state       <= L_RSP;
                                        end
                                end
                                default: begin
                                        if (!rsp_req && !rsp_ack) begin
                                                rsp_req <= 1'b1;
                                        end else if (rsp_req && rsp_ack) begin
                                                rsp_req <= 1'b0;
                                                state   <= L_IDLE;   // next item only now.
                                        end
                                end
                        endcase
                end
        end

        a_rsp_hold: assert property (@(posedge instruction_done) disable iff (!reset_n)
                rsp_req |=> $stable(rsp));

endmodule

// File: hw/fetcher.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// fetcher: reads opcode, operand and pointer bytes, decodes the
// group one addressing mode and forms ea and next pc.
// ~~~~~~~~~~~~~~~~~~~~
module fetcher import fetch_pkg::*; (
        input  logic        instruction_done,
        input  logic        reset_n,
        input  logic        cmd_req,
        input  fetch_cmd_t  cmd,
        output logic        cmd_ack,
        output mem_req_t    mreq,
        input  mem_rsp_t    mrsp,
        output logic        item_req,
        output fetch_item_t item,
        input  logic        item_ack
);

        typedef enum logic [1:0] {F_IDLE, F_MEM, F_GAP, F_ITEM} fstate_t;
        typedef enum logic [2:0] {S_OPCODE, S_B1, S_B2, S_PTR_LO, S_PTR_HI} step_t;

        fstate_t               state;
        step_t                 step;
        fetch_cmd_t            cmd_r;
        opcode_u               op_r;
        opcode_u               op_in;
        logic [DATA_WIDTH-1:0] ptr;
        logic [DATA_WIDTH-1:0] zp_x;
        logic [DATA_WIDTH-1:0] idx;

        assign op_in.raw = mrsp.data;
        assign zp_x      = mrsp.data + cmd_r.x;   // zero page wrap.

        always_comb begin
                case (op_r.f.mode)
                        AM_ABS_X:           idx = cmd_r.x;
                        AM_ABS_Y, AM_IND_Y: idx = cmd_r.y;
                        default:            idx = '0;
                endcase
        end

        always_ff @(posedge instruction_done) begin
                if (!reset_n) begin
                        state    <= F_IDLE;
                        step     <= S_OPCODE;
                        cmd_ack  <= 1'b0;
                        mreq.req <= 1'b0;
                        item_req <= 1'b0;
                end else begin
                        if (cmd_ack && !cmd_req) begin
                                cmd_ack <= 1'b0;
                        end
                        case (state)
                                F_IDLE: begin
                                        if (cmd_req && !cmd_ack && !mrsp.ack) begin
                                                cmd_r     <= cmd;
                                                cmd_ack   <= 1'b1;
                                                mreq.req  <= 1'b1;
                                                mreq.addr <= cmd.pc;
                                                step      <= S_OPCODE;
                                                state     <= F_MEM;
                                        end
                                end
                                F_MEM: begin
                                        if (mrsp.ack) begin
                                                mreq.req <= 1'b0;
                                                state    <= F_GAP;
                                                case (step)
                                                        S_OPCODE: begin
                                                                op_r         <= op_in;
                                                                item.opcode  <= op_in.raw;
                                                                item.ea      <= '0;
                                                                item.operand <= '0;
                                                                mreq.addr    <= cmd_r.pc + 16'd1;
                                                                step         <= S_B1;
                                                                if (op_in.f.group != GROUP_ONE) begin
                                                                        item.illegal    <= 1'b1;
                                                                        item.needs_load <= 1'b0;
                                                                        item.next_pc    <= cmd_r.pc + 16'd1;
                                                                        state           <= F_ITEM;
                                                                end else begin
                                                                        item.illegal    <= 1'b0;
                                                                        item.needs_load <= op_in.f.mode != AM_IMM;
                                                                        item.next_pc    <= cmd_r.pc +
                                                                                (op_in.f.mode inside
                                                                                 {AM_ABS, AM_ABS_X, AM_ABS_Y} ?
                                                                                 16'd3 : 16'd2);
                                                                end
                                                        end
                                                        S_B1: begin
                                                                case (op_r.f.mode)
                                                                        AM_IMM: begin
                                                                                item.ea      <= cmd_r.pc + 16'd1;
                                                                                item.operand <= mrsp.data;
                                                                                state        <= F_ITEM;
                                                                        end
                                                                        AM_ZPG: begin
                                                                                item.ea <= {8'h00, mrsp.data};
                                                                                state   <= F_ITEM;
                                                                        end
                                                                        AM_ZPG_X: begin
                                                                                item.ea <= {8'h00, zp_x};
                                                                                state   <= F_ITEM;
                                                                        end
                                                                        AM_X_IND: begin
                                                                                ptr       <= zp_x;
                                                                                mreq.addr <= {8'h00, zp_x};
                                                                                step      <= S_PTR_LO;
                                                                        end
                                                                        AM_IND_Y: begin
                                                                                ptr       <= mrsp.data;
                                                                                mreq.addr <= {8'h00, mrsp.data};
                                                                                step      <= S_PTR_LO;
                                                                        end
                                                                        default: begin   // absolute modes.
                                                                                item.ea[7:0] <= mrsp.data;
                                                                                mreq.addr    <= cmd_r.pc + 16'd2;
                                                                                step         <= S_B2;
                                                                        end
                                                                endcase
                                                        end
                                                        S_PTR_LO: begin
                                                                item.ea[7:0] <= mrsp.data;
                                                                ptr          <= ptr + 8'd1;
                                                                mreq.addr    <= {8'h00, ptr + 8'd1};
                                                                step         <= S_PTR_HI;
                                                        end
                                                        default: begin   // high byte, then index.
                                                                item.ea <= {mrsp.data, item.ea[7:0]} +
                                                                           {8'h00, idx};
                                                                state   <= F_ITEM;
                                                        end
                                                endcase
                                        end
                                end
                                F_GAP: begin
                                        if (!mrsp.ack) begin
                                                mreq.req <= 1'b1;
                                                state    <= F_MEM;
                                        end
                                end
                                default: begin
                                        if (!item_req && !item_ack) begin
                                                item_req <= 1'b1;
                                        end else if (item_req && item_ack) begin
                                                item_req <= 1'b0;
                                                state    <= F_IDLE;
                                        end
                                end
                        endcase
                end
        end

        a_addr_hold: assert property (@(posedge instruction_done) disable iff (!reset_n)
                mreq.req && !mrsp.ack |=> $stable(mreq.addr));

        a_item_hold: assert property (@(posedge instruction_done) disable iff (!reset_n)
                item_req |=> $stable(item));

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// memory arbiter: round-robin between fetcher and loader,
// four-phase req/ack toward each, one grant at a time.
// ~~~~~~~~~~~~~~~~~~~~
module mem_arbiter import fetch_pkg::*; (
        input  logic                  instruction_done,
        input  logic                  reset_n,
        input  mem_req_t              fetch_mreq,
        output mem_rsp_t              fetch_mrsp,
        input  mem_req_t              load_mreq,
        output mem_rsp_t              load_mrsp,
        output logic [ADDR_WIDTH-1:0] rd_addr,
        input  logic [DATA_WIDTH-1:0] rd_data
);

        typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT, ARB_ACK} arb_state_t;

        arb_state_t state;
        logic       owner;      // 0 fetcher, 1 loader.
        logic       prio;       // preferred side on contention.
        logic       owner_req;
        logic       fetch_ack;
        logic       load_ack;

        assign owner_req = owner ? load_mreq.req : fetch_mreq.req;
        assign rd_addr   = owner ? load_mreq.addr : fetch_mreq.addr;

        // memory keeps re-reading the owner's address, so data holds.
        assign fetch_mrsp = '{ack: fetch_ack, data: rd_data};
        assign load_mrsp  = '{ack: load_ack, data: rd_data};

        always_ff @(posedge instruction_done) begin
                if (!reset_n) begin
                        state     <= ARB_IDLE;
                        owner     <= 1'b0;
                        prio      <= 1'b0;
                        fetch_ack <= 1'b0;
                        load_ack  <= 1'b0;
                end else begin
                        case (state)
                                ARB_IDLE: begin
                                        if (fetch_mreq.req || load_mreq.req) begin
                                                owner <= (fetch_mreq.req && load_mreq.req) ?
                                                         prio : load_mreq.req;
                                                state <= ARB_GRANT;
                                        end
                                end
                                ARB_GRANT: begin
                                        fetch_ack <= !owner;   // read in flight.
                                        load_ack  <= owner;
                                        state     <= ARB_ACK;
                                end
                                ARB_ACK: begin
                                        if (!owner_req) begin
                                                fetch_ack <= 1'b0;
                                                load_ack  <= 1'b0;
                                                prio      <= ~owner;
                                                state     <= ARB_IDLE;
                                        end
                                end
                                default: begin
                                        fetch_ack <= 1'b0;
                                        load_ack  <= 1'b0;
                                        state     <= ARB_IDLE;
                                end
                        endcase
                end
        end

        a_one_ack: assert property (@(posedge instruction_done) disable iff (!reset_n)
                !(fetch_mrsp.ack && load_mrsp.ack));

endmodule

// File: hw/program_memory.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// program memory: 64 KiB of bytes, registered read, preload write.
// ~~~~~~~~~~~~~~~~~~~~
module program_memory import fetch_pkg::*; (
        input  logic                  instruction_done,
        input  logic                  reset_n,
        input  logic [ADDR_WIDTH-1:0] rd_addr,
        output logic [DATA_WIDTH-1:0] rd_data,
        input  logic                  load_en,
        input  logic [ADDR_WIDTH-1:0] load_addr,
        input  logic [DATA_WIDTH-1:0] load_data
);

        logic [DATA_WIDTH-1:0] mem [0:2**ADDR_WIDTH-1];

        always_ff @(posedge instruction_done) begin
                if (reset_n && load_en) begin
                        mem[load_addr] <= load_data;   // no preload during reset.
                end
                rd_data <= mem[rd_addr];               // one cycle read latency.
        end

endmodule

// File: hw/fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// fetch package: bus widths, addressing-mode codes, opcode view
// and the structs passed between fetch unit blocks.
// ~~~~~~~~~~~~~~~~~~~~
package fetch_pkg;

        localparam int ADDR_WIDTH = 16;
        localparam int DATA_WIDTH = 8;

        // group one middle field, bits 4:2 of the opcode.
        localparam logic [2:0] AM_X_IND = 3'd0;
        localparam logic [2:0] AM_ZPG   = 3'd1;
        localparam logic [2:0] AM_IMM   = 3'd2;
        localparam logic [2:0] AM_ABS   = 3'd3;
        localparam logic [2:0] AM_IND_Y = 3'd4;
        localparam logic [2:0] AM_ZPG_X = 3'd5;
        localparam logic [2:0] AM_ABS_Y = 3'd6;
        localparam logic [2:0] AM_ABS_X = 3'd7;

        localparam logic [1:0] GROUP_ONE = 2'b01;

        typedef struct packed {
                logic [2:0] op_a;
                logic [2:0] mode;
                logic [1:0] group;
        } opcode_fields_t;

        typedef union packed {
                logic [DATA_WIDTH-1:0] raw;
                opcode_fields_t        f;
        } opcode_u;

        typedef struct packed {
                logic [ADDR_WIDTH-1:0] pc;
                logic [DATA_WIDTH-1:0] x;
                logic [DATA_WIDTH-1:0] y;
        } fetch_cmd_t;

        typedef struct packed {
                logic                  req;
                logic [ADDR_WIDTH-1:0] addr;
        } mem_req_t;

        typedef struct packed {
                logic                  ack;
                logic [DATA_WIDTH-1:0] data;
        } mem_rsp_t;

        typedef struct packed {
                logic [DATA_WIDTH-1:0] opcode;
                logic [ADDR_WIDTH-1:0] ea;
                logic [DATA_WIDTH-1:0] operand;   // set here only for immediate.
                logic [ADDR_WIDTH-1:0] next_pc;
                logic                  needs_load;
                logic                  illegal;
        } fetch_item_t;

        typedef struct packed {
                logic [DATA_WIDTH-1:0] opcode;
                logic [ADDR_WIDTH-1:0] ea;
                logic [DATA_WIDTH-1:0] operand;
                logic [ADDR_WIDTH-1:0] next_pc;
                logic                  illegal;
        } fetch_result_t;

endpackage
